// File: common/noc_pkg.sv
package noc_pkg;

    localparam int FLIT_WIDTH = 32;
    localparam int MAX_FLITS  = 8;
    localparam int SLOT_COUNT = 2;

    localparam int FLIT_IDX_WIDTH = $clog2(MAX_FLITS);  // Selects a flit inside a buffer
    localparam int SLOT_IDX_WIDTH = $clog2(SLOT_COUNT);

    typedef logic [FLIT_WIDTH-1:0] flit_t;

    // Counts flits, so tail_index is the packet length
    typedef logic [3:0] flit_num_t;

    typedef logic [3:0] cpu_addr_t;

    typedef logic [SLOT_IDX_WIDTH-1:0] slot_idx_t;

    // 0 to 7 are flit words
    localparam cpu_addr_t CPU_ADDR_LAUNCH = 4'd8;

    typedef struct packed {
        flit_t [MAX_FLITS-1:0] buffer;
        flit_num_t             tail_index;
    } packet_element_t;

endpackage

// File: packet_store/packet_store.sv
`timescale 1ns/1ps

module packet_store
    import noc_pkg::*;
(
    input  logic            nocclk,
    input  logic            rst_n,

    input  flit_t           in_flit,
    input  logic            in_flit_last,
    input  logic            in_flit_valid,
    output logic            in_flit_ready,

    output packet_element_t transfered_packet,
    output logic            transfered_packet_valid,
    input  logic            transfered_packet_completed
);

    packet_element_t       slot_buf [SLOT_COUNT];
    logic [SLOT_COUNT-1:0] slot_full;
    logic [SLOT_COUNT-1:0] full_next;
    slot_idx_t             fill_ptr;
    slot_idx_t             fill_ptr_next;
    slot_idx_t             rd_ptr;
    flit_num_t             wr_idx;
    logic                  accept;

    assign accept = in_flit_valid && in_flit_ready;

    always_comb begin
        full_next     = slot_full;
        fill_ptr_next = fill_ptr;
        if (transfered_packet_completed) begin
            full_next[rd_ptr] = 1'b0;
        end
        if (accept && in_flit_last) begin
            full_next[fill_ptr] = 1'b1;
            fill_ptr_next       = fill_ptr + 1'b1;
        end
    end

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full     <= '0;
            fill_ptr      <= '0;
            rd_ptr        <= '0;
            wr_idx        <= '0;
            in_flit_ready <= 1'b0;
        end else begin
            slot_full     <= full_next;
            fill_ptr      <= fill_ptr_next;
            in_flit_ready <= !full_next[fill_ptr_next];  // Fill slot still free
            if (transfered_packet_completed) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (accept) begin
                wr_idx <= in_flit_last ? '0 : wr_idx + 4'd1;
            end
        end
    end

    // Slot payload
    always_ff @(posedge nocclk) begin
        if (accept) begin
            slot_buf[fill_ptr].buffer[wr_idx[FLIT_IDX_WIDTH-1:0]] <= in_flit;
            if (in_flit_last) begin
                slot_buf[fill_ptr].tail_index <= wr_idx + 4'd1;
            end
        end
    end

    // Oldest finished slot
    assign transfered_packet       = slot_buf[rd_ptr];
    assign transfered_packet_valid = slot_full[rd_ptr];

    a_max_len: assert property (
        @(posedge nocclk) disable iff (!rst_n)
        (accept && (wr_idx == flit_num_t'(MAX_FLITS - 1))) |-> in_flit_last
    );

endmodule

// File: cpu_port/cpu_packet_regs.sv
`timescale 1ns/1ps

module cpu_packet_regs
    import noc_pkg::*;
(
    input  logic            nocclk,
    input  logic            rst_n,

    input  logic            cpu_req,
    input  cpu_addr_t       cpu_addr,
    input  flit_t           cpu_wdata,
    output logic            cpu_ack,

    output packet_element_t cpu_transfered_packet,
    output logic            cpu_transfered_packet_valid,
    input  logic            cpu_transfered_packet_completed
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } hs_state_t;

    hs_state_t       state;
    packet_element_t pkt;
    logic            pending;
    logic            wr_en;
    logic            launch;
    flit_num_t       launch_len;

    // No new write while a launched packet is out
    assign wr_en      = (state == WAIT_REQ) && cpu_req && !pending;
    assign launch_len = cpu_wdata[3:0];
    assign launch     = wr_en && (cpu_addr == CPU_ADDR_LAUNCH) && (launch_len != '0) &&
                        (launch_len <= flit_num_t'(MAX_FLITS));

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WAIT_REQ;
            cpu_ack <= 1'b0;
            pending <= 1'b0;
        end else begin
            case (state)
                WAIT_REQ: begin
                    if (wr_en) begin
                        cpu_ack <= 1'b1;
                        state   <= WAIT_DROP;
                    end
                end
                default: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= WAIT_REQ;
                    end
                end
            endcase
            if (launch) begin
                pending <= 1'b1;
            end else if (cpu_transfered_packet_completed) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge nocclk) begin
        if (wr_en && (cpu_addr < cpu_addr_t'(MAX_FLITS))) begin
            pkt.buffer[cpu_addr[FLIT_IDX_WIDTH-1:0]] <= cpu_wdata;
        end
        if (launch) begin
            pkt.tail_index <= launch_len;
        end
    end

    assign cpu_transfered_packet       = pkt;
    assign cpu_transfered_packet_valid = pending;

    a_ack_with_req: assert property (
        @(posedge nocclk) disable iff (!rst_n)
        $rose(cpu_ack) |-> cpu_req
    );

endmodule

// File: rtl/packet_transfer_buffer.sv
`timescale 1ns/1ps

module packet_transfer_buffer
    import noc_pkg::*;
(
    input  logic            nocclk,
    input  logic            rst_n,

    input  packet_element_t transfered_packet,
    input  logic            transfered_packet_valid,
    output logic            transfered_packet_completed,  // One cycle, frees the store slot

    input  packet_element_t cpu_transfered_packet,
    input  logic            cpu_transfered_packet_valid,
    output logic            cpu_transfered_packet_completed,

    input  logic            transfered_flit_ready,
    output logic            transfered_flit_valid,
    output flit_t           transfered_flit,
    output flit_t           transfered_head_flit
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_LINK,
        SEND_CPU
    } state_t;

    state_t    state;
    flit_num_t current_flit_num;
    flit_num_t next_flit_num;
    logic      is_end_of_packet;
    logic      flit_handshake;

    assign next_flit_num  = current_flit_num + 4'd1;
    assign flit_handshake = transfered_flit_valid && transfered_flit_ready;

    always_comb begin
        case (state)
            SEND_LINK: begin
                is_end_of_packet      = transfered_packet.tail_index == next_flit_num;
                transfered_flit_valid = transfered_packet_valid &&
                                        (transfered_packet.tail_index > current_flit_num);
                transfered_flit       =
                    transfered_packet.buffer[current_flit_num[FLIT_IDX_WIDTH-1:0]];
                transfered_head_flit  = transfered_packet.buffer[0];
            end
            SEND_CPU: begin
                is_end_of_packet      = cpu_transfered_packet.tail_index == next_flit_num;
                transfered_flit_valid = cpu_transfered_packet_valid &&
                                        (cpu_transfered_packet.tail_index > current_flit_num);
                transfered_flit       =
                    cpu_transfered_packet.buffer[current_flit_num[FLIT_IDX_WIDTH-1:0]];
                transfered_head_flit  = cpu_transfered_packet.buffer[0];
            end
            default: begin
                is_end_of_packet      = 1'b0;
                transfered_flit_valid = 1'b0;
                transfered_flit       = '0;
                transfered_head_flit  = '0;
            end
        endcase
    end

    // Packet ends only when its last flit is taken
    assign transfered_packet_completed =
        (state == SEND_LINK) && flit_handshake && is_end_of_packet;
    assign cpu_transfered_packet_completed =
        (state == SEND_CPU) && flit_handshake && is_end_of_packet;

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            current_flit_num <= '0;
        end else if (state == IDLE) begin
            current_flit_num <= '0;
        end else if (flit_handshake) begin
            current_flit_num <= is_end_of_packet ? '0 : next_flit_num;
        end
    end

    always_ff @(posedge nocclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (transfered_packet_valid) begin  // Link side wins
                        state <= SEND_LINK;
                    end else if (cpu_transfered_packet_valid) begin
                        state <= SEND_CPU;
                    end
                end
                SEND_LINK, SEND_CPU: begin
                    if (flit_handshake && is_end_of_packet) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Sources must hold their packet until completion
    a_flit_stable: assert property (
        @(posedge nocclk) disable iff (!rst_n)
        (transfered_flit_valid && !transfered_flit_ready) |=>
            (transfered_flit_valid && $stable(transfered_flit))
    );

    a_one_completion: assert property (
        @(posedge nocclk) disable iff (!rst_n)
        !(transfered_packet_completed && cpu_transfered_packet_completed)
    );

endmodule

// File: rtl/noc_tx_top.sv
`timescale 1ns/1ps

module noc_tx_top
    import noc_pkg::*;
(
    input  logic      nocclk,
    input  logic      rst_n,

    input  flit_t     in_flit,
    input  logic      in_flit_last,
    input  logic      in_flit_valid,
    output logic      in_flit_ready,

    input  logic      cpu_req,
    input  cpu_addr_t cpu_addr,
    input  flit_t     cpu_wdata,
    output logic      cpu_ack,

    input  logic      transfered_flit_ready,
    output logic      transfered_flit_valid,
    output flit_t     transfered_flit,
    output flit_t     transfered_head_flit
);

    packet_element_t transfered_packet;
    logic            transfered_packet_valid;
    logic            transfered_packet_completed;
    packet_element_t cpu_transfered_packet;
    logic            cpu_transfered_packet_valid;
    logic            cpu_transfered_packet_completed;

    packet_store i_packet_store (
        .nocclk                      (nocclk),
        .rst_n                       (rst_n),
        .in_flit                     (in_flit),
        .in_flit_last                (in_flit_last),
        .in_flit_valid               (in_flit_valid),
        .in_flit_ready               (in_flit_ready),
        .transfered_packet           (transfered_packet),
        .transfered_packet_valid     (transfered_packet_valid),
        .transfered_packet_completed (transfered_packet_completed)
    );

    cpu_packet_regs i_cpu_packet_regs (
        .nocclk                          (nocclk),
        .rst_n                           (rst_n),
        .cpu_req                         (cpu_req),
        .cpu_addr                        (cpu_addr),
        .cpu_wdata                       (cpu_wdata),
        .cpu_ack                         (cpu_ack),
        .cpu_transfered_packet           (cpu_transfered_packet),
        .cpu_transfered_packet_valid     (cpu_transfered_packet_valid),
        .cpu_transfered_packet_completed (cpu_transfered_packet_completed)
    );

    packet_transfer_buffer i_packet_transfer_buffer (
        .nocclk                          (nocclk),
        .rst_n                           (rst_n),
        .transfered_packet               (transfered_packet),
        .transfered_packet_valid         (transfered_packet_valid),
        .transfered_packet_completed     (transfered_packet_completed),
        .cpu_transfered_packet           (cpu_transfered_packet),
        .cpu_transfered_packet_valid     (cpu_transfered_packet_valid),
        .cpu_transfered_packet_completed (cpu_transfered_packet_completed),
        .transfered_flit_ready           (transfered_flit_ready),
        .transfered_flit_valid           (transfered_flit_valid),
        .transfered_flit                 (transfered_flit),
        .transfered_head_flit            (transfered_head_flit)
    );

endmodule

// File: bench/tb_noc_tx_model.svh
`ifndef TB_NOC_TX_MODEL_SVH
`define TB_NOC_TX_MODEL_SVH

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        data_lfsr = lfsr_next(data_lfsr);  // One step per bit
        bits      = {bits[30:0], data_lfsr[0]};
    end
    return bits;
endfunction

function automatic flit_num_t random_len();
    return flit_num_t'(take_bits(3) + 32'd1);
endfunction

// Expected packet, head bit 31 tags the source
function automatic packet_element_t make_packet(input logic is_cpu, input flit_num_t len);
    packet_element_t pkt;
    pkt = '0;
    for (int i = 0; i < int'(len); i++) begin
        pkt.buffer[FLIT_IDX_WIDTH'(i)] = take_bits(FLIT_WIDTH);
    end
    pkt.buffer[0][FLIT_WIDTH-1] = is_cpu;
    pkt.tail_index              = len;
    return pkt;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("FAILED at %0t: %s got %h expected %h",
                                 $time, what, got, exp));
    end
endtask

`endif

// File: bench/tb_noc_tx.sv
`timescale 1ns/1ps

module tb_noc_tx
    import noc_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int TOTAL_PACKETS   = 22;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_PACKETS;
    localparam int READY_HIGH      = 0;
    localparam int READY_RANDOM    = 1;
    localparam int READY_LOW       = 2;

    logic      nocclk;
    logic      rst_n;
    flit_t     in_flit;
    logic      in_flit_last;
    logic      in_flit_valid;
    logic      in_flit_ready;
    logic      cpu_req;
    cpu_addr_t cpu_addr;
    flit_t     cpu_wdata;
    logic      cpu_ack;
    logic      transfered_flit_ready;
    logic      transfered_flit_valid;
    flit_t     transfered_flit;
    flit_t     transfered_head_flit;

    logic [31:0]     data_lfsr;
    logic [31:0]     ready_lfsr;
    int              ready_mode;
    int              error_count;
    packet_element_t exp_link_q[$];
    packet_element_t exp_cpu_q[$];
    packet_element_t got_q[$];
    packet_element_t got_head_q[$];
    logic            out_tags[$];
    packet_element_t cur_pkt;
    packet_element_t cur_heads;
    int              cur_len;
    logic            stalled;
    flit_t           held_flit;

    `include "tb_noc_tx_model.svh"

    noc_tx_top i_noc_tx_top (.*);

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic send_link_packet(input flit_num_t len);
        packet_element_t pkt;
        pkt = make_packet(1'b0, len);
        exp_link_q.push_back(pkt);
        for (int i = 0; i < int'(len); i++) begin
            in_flit       = pkt.buffer[FLIT_IDX_WIDTH'(i)];
            in_flit_last  = (i == int'(len) - 1);
            in_flit_valid = 1'b1;
            do @(negedge nocclk); while (!in_flit_ready);
            @(posedge nocclk);
            #1;
        end
        in_flit_valid = 1'b0;
        in_flit_last  = 1'b0;
    endtask

    task automatic cpu_write(input cpu_addr_t addr, input flit_t data, input logic immediate);
        int waited;
        waited    = 0;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_req   = 1'b1;
        do begin
            @(negedge nocclk);
            waited++;
        end while (!cpu_ack);
        if (immediate) check_value("cpu_ack latency", 32'(waited), 32'd2);  // Req seen at next edge
        @(posedge nocclk);
        #1;
        cpu_req = 1'b0;
        @(posedge nocclk);
        @(negedge nocclk);
        check_value("cpu_ack after req dropped", 32'(cpu_ack), 32'd0);
        @(posedge nocclk);
        #1;
    endtask

    task automatic send_cpu_packet(input flit_num_t len);
        packet_element_t pkt;
        pkt = make_packet(1'b1, len);
        exp_cpu_q.push_back(pkt);
        for (int i = 0; i < int'(len); i++) begin
            cpu_write(cpu_addr_t'(i), pkt.buffer[FLIT_IDX_WIDTH'(i)], i != 0);
        end
        cpu_write(CPU_ADDR_LAUNCH, 32'(len), 1'b1);
    endtask

    task automatic wait_drain();
        do @(negedge nocclk);
        while (exp_link_q.size() + exp_cpu_q.size() + got_q.size() != 0 || cur_len != 0);
        @(posedge nocclk);
        #1;
    endtask

    initial begin
        nocclk = 1'b0;
        forever #(CLK_PERIOD / 2) nocclk = ~nocclk;
    end

    initial begin
        forever begin
            @(posedge nocclk);
            #1;
            if (ready_mode == READY_RANDOM) begin
                ready_lfsr            = lfsr_next(ready_lfsr);
                transfered_flit_ready = ready_lfsr[0];
            end else begin
                transfered_flit_ready = (ready_mode == READY_HIGH);
            end
        end
    end

    // Packets are separated by at least one cycle without valid
    always @(negedge nocclk) begin
        if (rst_n) begin
            if (stalled) begin
                check_value("valid under back-pressure", 32'(transfered_flit_valid), 32'd1);
                check_value("flit under back-pressure", transfered_flit, held_flit);
            end
            if (transfered_flit_valid && transfered_flit_ready) begin
                if (cur_len == MAX_FLITS) report_failure("Output packet longer than MAX_FLITS");
                cur_pkt.buffer[FLIT_IDX_WIDTH'(cur_len)]   = transfered_flit;
                cur_heads.buffer[FLIT_IDX_WIDTH'(cur_len)] = transfered_head_flit;
                cur_len++;
            end else if (!transfered_flit_valid && cur_len != 0) begin
                cur_pkt.tail_index = flit_num_t'(cur_len);
                got_q.push_back(cur_pkt);
                got_head_q.push_back(cur_heads);
                cur_len = 0;
            end
            stalled   = transfered_flit_valid && !transfered_flit_ready;
            held_flit = transfered_flit;
        end
    end

    initial begin : compare_proc
        packet_element_t got;
        packet_element_t heads;
        packet_element_t exp;
        logic            is_cpu;
        forever begin
            @(posedge nocclk);
            if (got_q.size() != 0) begin
                got    = got_q.pop_front();
                heads  = got_head_q.pop_front();
                is_cpu = got.buffer[0][FLIT_WIDTH-1];
                out_tags.push_back(is_cpu);
                if ((is_cpu ? exp_cpu_q.size() : exp_link_q.size()) == 0) begin
                    report_failure("A packet came out that was never sent");
                end else begin
                    exp = is_cpu ? exp_cpu_q.pop_front() : exp_link_q.pop_front();
                    check_value("packet length", 32'(got.tail_index), 32'(exp.tail_index));
                    for (int i = 0; i < int'(exp.tail_index); i++) begin
                        check_value($sformatf("flit %0d", i),
                                    got.buffer[FLIT_IDX_WIDTH'(i)], exp.buffer[FLIT_IDX_WIDTH'(i)]);
                        check_value("head flit", heads.buffer[FLIT_IDX_WIDTH'(i)], exp.buffer[0]);
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge nocclk);
        report_failure("Timeout: the packets did not all come out within the cycle budget");
    end

    initial begin
        int base;
        {rst_n, in_flit, in_flit_last, in_flit_valid} = '0;
        {cpu_req, cpu_addr, cpu_wdata, transfered_flit_ready} = '0;
        {data_lfsr, ready_lfsr} = {32'hf829_bbac, 32'hf829_bbac};
        {ready_mode, error_count, cur_len, stalled} = {READY_LOW, 32'd0, 32'd0, 1'b0};
        repeat (2) @(posedge nocclk);
        @(negedge nocclk);
        check_value("outputs in reset", 32'({transfered_flit_valid, cpu_ack, in_flit_ready}), 32'd0);
        @(posedge nocclk);
        #1;
        rst_n = 1'b1;
        @(posedge nocclk);
        @(negedge nocclk);
        check_value("in_flit_ready after reset", 32'(in_flit_ready), 32'd1);
        @(posedge nocclk);
        #1;

        ready_mode = READY_HIGH;
        send_link_packet(flit_num_t'(MAX_FLITS));
        send_link_packet(4'd1);
        repeat (4) send_link_packet(random_len());
        repeat (4) send_cpu_packet(random_len());
        wait_drain();

        // Link and CPU packets waiting together
        ready_mode = READY_LOW;
        base       = out_tags.size();
        send_link_packet(random_len());
        send_cpu_packet(random_len());
        send_link_packet(random_len());
        ready_mode = READY_HIGH;
        wait_drain();
        check_value("source order", {29'd0, out_tags[base], out_tags[base+1], out_tags[base+2]}, 32'd1);

        ready_mode = READY_RANDOM;
        for (int k = 0; k < 6; k++) begin
            if (k == 1 || k == 4) send_cpu_packet(random_len());
            else send_link_packet(random_len());
        end
        wait_drain();

        ready_mode = READY_LOW;
        send_link_packet(random_len());
        send_link_packet(random_len());
        @(negedge nocclk);
        check_value("in_flit_ready with both slots full", 32'(in_flit_ready), 32'd0);
        fork
            send_link_packet(random_len());
            begin
                repeat (10) @(negedge nocclk);
                check_value("in_flit_ready still stalled", 32'(in_flit_ready), 32'd0);
                ready_mode = READY_HIGH;
            end
        join
        wait_drain();

        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

// File: verilog.f
+incdir+bench
common/noc_pkg.sv
packet_store/packet_store.sv
cpu_port/cpu_packet_regs.sv
rtl/packet_transfer_buffer.sv
rtl/noc_tx_top.sv
bench/tb_noc_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_tx
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
